// ==== list.f ====
+incdir+source
source/mips_isa_pkg.sv
source/mips_ctrl_pkg.sv
source/instruction_fetch.sv
source/decode.sv
source/execute.sv
source/memory.sv
source/top.sv
verification/top_tb.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mips_isa_pkg.sv
      - source/mips_ctrl_pkg.sv
      - source/instruction_fetch.sv
      - source/decode.sv
      - source/execute.sv
      - source/memory.sv
      - source/top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/top_tb.sv

// ==== verification/top_tb.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module top_tb;
	import mips_isa_pkg::*;

	logic                 clk;
	logic                 arst_n;
	logic                 run;
	logic                 imem_we;
	logic [`IMEM_AW-1:0]  imem_addr;
	instr_t               imem_wdata;
	logic                 wb_en;
	logic [`MIPS_NB-1:0]  wb_reg;
	logic [`MIPS_LEN-1:0] wb_data;

	// Program being built and the retire lists
	instr_t               prog [$];
	logic [`MIPS_NB-1:0]  exp_reg [$];
	logic [`MIPS_LEN-1:0] exp_data [$];
	logic [`MIPS_NB-1:0]  got_reg [$];
	logic [`MIPS_LEN-1:0] got_data [$];

	// Architectural model of registers and data memory
	logic [`MIPS_LEN-1:0] mregs [2**`MIPS_NB];
	logic [`MIPS_LEN-1:0] mmem [`DMEM_DEPTH];

	integer seed;
	int     cycles;
	int     cycle_limit;

	top uut (
		.clk(clk), .arst_n(arst_n), .run(run),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	always #2 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	// Only cycles with the core running count toward the limit
	always @(posedge clk) begin
		if (run) begin
			cycles++;
			if (cycles > cycle_limit)
				fail_run("Timeout: the expected retire events did not all arrive");
		end
	end

	// Retire trace sampled mid-cycle
	always @(negedge clk) begin
		if (arst_n && wb_en) begin
			got_reg.push_back(wb_reg);
			got_data.push_back(wb_data);
		end
	end

	task automatic check_reg(input string name, input logic [`MIPS_NB-1:0] got,
		input logic [`MIPS_NB-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic check_data(input string name, input logic [`MIPS_LEN-1:0] got,
		input logic [`MIPS_LEN-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	//////////////////////////////
	// Instruction encoders

	function automatic instr_t enc_r(funct_e fn, logic [4:0] rd, logic [4:0] rs,
		logic [4:0] rt, logic [4:0] sh);
		instr_t w;
		w.r.opcode = OP_RTYPE;
		w.r.rs     = rs;
		w.r.rt     = rt;
		w.r.rd     = rd;
		w.r.shamt  = sh;
		w.r.funct  = fn;
		return w;
	endfunction

	function automatic instr_t enc_i(opcode_e op, logic [4:0] rt, logic [4:0] rs,
		logic [15:0] imm);
		instr_t w;
		w.i.opcode = op;
		w.i.rs     = rs;
		w.i.rt     = rt;
		w.i.imm16  = imm;
		return w;
	endfunction

	function automatic logic [31:0] sext16(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	//////////////////////////////
	// Program builders with the model

	task automatic clear_model();
		prog.delete();
		exp_reg.delete();
		exp_data.delete();
		for (int i = 0; i < 2**`MIPS_NB; i++)
			mregs[i] = '0;
	endtask

	// r0 writes still show on the trace while the model keeps r0 at zero
	task automatic record_retire(input logic [4:0] rd, input logic [31:0] val);
		exp_reg.push_back(rd);
		exp_data.push_back(val);
		if (rd != 0)
			mregs[rd] = val;
	endtask

	task automatic alu_instr(input funct_e fn, input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] sh);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		a = mregs[rs];
		b = mregs[rt];
		case (fn)
			FN_ADDU: res = a + b;
			FN_SUBU: res = a - b;
			FN_AND:  res = a & b;
			FN_OR:   res = a | b;
			FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: res = b << sh;
		endcase
		prog.push_back(enc_r(fn, rd, rs, rt, sh));
		record_retire(rd, res);
	endtask

	task automatic add_imm(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
		prog.push_back(enc_i(OP_ADDIU, rt, rs, imm));
		record_retire(rt, mregs[rs] + sext16(imm));
	endtask

	task automatic store_word(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
		logic [31:0] addr;
		addr = mregs[rs] + sext16(imm);
		prog.push_back(enc_i(OP_SW, rt, rs, imm));
		mmem[addr[`DMEM_AW+1:2]] = mregs[rt];
	endtask

	task automatic load_word(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
		logic [31:0] addr;
		addr = mregs[rs] + sext16(imm);
		prog.push_back(enc_i(OP_LW, rt, rs, imm));
		record_retire(rt, mmem[addr[`DMEM_AW+1:2]]);
	endtask

	// Offset counts words from the slot after the branch
	task automatic branch_eq(input logic [4:0] rs, input logic [4:0] rt, input int target,
		output bit taken);
		logic [15:0] offset;
		offset = 16'(target - (prog.size() + 1));
		taken  = (mregs[rs] == mregs[rt]);
		prog.push_back(enc_i(OP_BEQ, rt, rs, offset));
	endtask

	task automatic jump_to(input int target);
		instr_t w;
		w.j.opcode   = OP_J;
		w.j.target26 = 26'(target);
		prog.push_back(w);
	endtask

	//////////////////////////////
	// DUT control

	task automatic reset_dut();
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 arst_n = 1'b1;
	endtask

	task automatic load_program();
		foreach (prog[i]) begin
			@(posedge clk);
			#1;
			imem_we    = 1'b1;
			imem_addr  = i;
			imem_wdata = prog[i];
		end
		@(posedge clk);
		#1 imem_we = 1'b0;
	endtask

	// Ends the program in a jump to itself and then runs and compares the trace
	task automatic run_program();
		jump_to(prog.size());
		prog.push_back(INSTR_NOP);
		load_program();
		reset_dut();
		got_reg.delete();
		got_data.delete();
		cycle_limit += prog.size() + 20;
		run = 1'b1;
		while (got_reg.size() < exp_reg.size())
			@(posedge clk);
		repeat (8) @(posedge clk);
		#1 run = 1'b0;
		if (got_reg.size() != exp_reg.size())
			fail_run($sformatf("Wrong number of retire events: %0d seen, %0d expected",
				got_reg.size(), exp_reg.size()));
		foreach (exp_reg[i]) begin
			check_reg($sformatf("wb_reg[%0d]", i), got_reg[i], exp_reg[i]);
			check_data($sformatf("wb_data[%0d]", i), got_data[i], exp_data[i]);
		end
	endtask

	//////////////////////////////
	// Directed tests

	// Instruction memory still holds the last program here
	task automatic test_idle();
		reset_dut();
		repeat (10) begin
			@(negedge clk);
			if (wb_en !== 1'b0)
				fail_run("wb_en was not low while the core was idle after reset");
		end
	endtask

	// Back to back ops exercise MEM and WB forwarding
	task automatic test_alu();
		logic [15:0] imm;
		logic [4:0]  sh;
		clear_model();
		for (int r = 1; r <= 4; r++) begin
			imm = $random(seed);
			add_imm(5'(r), 5'd0, imm);
		end
		sh = $random(seed);
		alu_instr(FN_ADDU, 5'd5, 5'd3, 5'd4, 5'd0);
		alu_instr(FN_SUBU, 5'd6, 5'd5, 5'd1, 5'd0);
		alu_instr(FN_AND, 5'd7, 5'd6, 5'd5, 5'd0);
		alu_instr(FN_OR, 5'd8, 5'd7, 5'd2, 5'd0);
		alu_instr(FN_SLT, 5'd9, 5'd8, 5'd6, 5'd0);
		alu_instr(FN_SLT, 5'd10, 5'd6, 5'd8, 5'd0);
		alu_instr(FN_SLL, 5'd11, 5'd0, 5'd8, sh);
		alu_instr(FN_SUBU, 5'd12, 5'd11, 5'd9, 5'd0);
		alu_instr(FN_SLT, 5'd13, 5'd11, 5'd3, 5'd0);
		run_program();
	endtask

	task automatic test_reg_zero();
		clear_model();
		add_imm(5'd0, 5'd0, 16'h1234);
		alu_instr(FN_ADDU, 5'd1, 5'd0, 5'd0, 5'd0);
		add_imm(5'd2, 5'd0, 16'h0005);
		alu_instr(FN_OR, 5'd3, 5'd0, 5'd2, 5'd0);
		add_imm(5'd4, 5'd0, 16'h0000);
		run_program();
	endtask

	task automatic test_memory();
		clear_model();
		add_imm(5'd1, 5'd0, $random(seed));
		add_imm(5'd2, 5'd0, 16'hfff9);
		add_imm(5'd3, 5'd0, 16'h0008);
		store_word(5'd1, 5'd3, 16'h0000);
		store_word(5'd2, 5'd3, 16'h0004);
		add_imm(5'd3, 5'd3, 16'h0004);
		load_word(5'd4, 5'd3, 16'hfffc);
		load_word(5'd5, 5'd3, 16'h0000);
		prog.push_back(INSTR_NOP);
		alu_instr(FN_ADDU, 5'd6, 5'd4, 5'd5, 5'd0);
		run_program();
	endtask

	task automatic test_branch();
		bit taken;
		clear_model();
		add_imm(5'd1, 5'd0, 16'h0003);
		add_imm(5'd2, 5'd0, 16'h0003);
		add_imm(5'd3, 5'd0, 16'h0004);
		branch_eq(5'd1, 5'd3, 11, taken);
		add_imm(5'd4, 5'd0, 16'h0001);
		add_imm(5'd5, 5'd0, 16'h0002);
		add_imm(5'd6, 5'd0, 16'h0003);
		branch_eq(5'd1, 5'd2, 12, taken);
		add_imm(5'd7, 5'd0, 16'h0007);
		add_imm(5'd8, 5'd0, 16'h0008);
		add_imm(5'd9, 5'd0, 16'h0009);
		// Slot 11 lies on the not-taken path only
		if (taken)
			prog.push_back(enc_i(OP_ADDIU, 5'd10, 5'd0, 16'h0077));
		else
			add_imm(5'd10, 5'd0, 16'h0077);
		add_imm(5'd11, 5'd0, 16'h0009);
		run_program();
	endtask

	task automatic test_jumps();
		clear_model();
		add_imm(5'd1, 5'd0, 16'd32);
		jump_to(4);
		add_imm(5'd2, 5'd0, 16'h0021);
		prog.push_back(enc_i(OP_ADDIU, 5'd3, 5'd0, 16'h0031));
		add_imm(5'd4, 5'd0, 16'h0041);
		prog.push_back(enc_r(FN_JR, 5'd0, 5'd1, 5'd0, 5'd0));
		add_imm(5'd5, 5'd0, 16'h0051);
		prog.push_back(enc_i(OP_ADDIU, 5'd6, 5'd0, 16'h0061));
		add_imm(5'd7, 5'd0, 16'h0071);
		run_program();
	endtask

	initial begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		run         = 1'b0;
		imem_we     = 1'b0;
		imem_addr   = '0;
		imem_wdata  = INSTR_NOP;
		seed        = 32'hd0ec67d6;
		cycles      = 0;
		cycle_limit = 0;
		test_alu();
		test_reg_zero();
		test_memory();
		test_branch();
		test_jumps();
		test_idle();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== source/top.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 run,
	input  logic                 imem_we,
	input  logic [`IMEM_AW-1:0]  imem_addr,
	input  mips_isa_pkg::instr_t imem_wdata,
	output logic                 wb_en,
	output logic [`MIPS_NB-1:0]  wb_reg,
	output logic [`MIPS_LEN-1:0] wb_data
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	// IF to ID
	logic [`MIPS_LEN-1:0] if_pc_plus4;
	instr_t               if_instruction;

	// ID outputs
	logic [`MIPS_LEN-1:0] id_pc_plus4, id_reg1, id_reg2, id_sign_ext;
	logic [`MIPS_LEN-1:0] id_jump_target, id_reg_target;
	logic [`MIPS_NB-1:0]  id_rs, id_rt, id_rd, id_shamt;
	logic                 id_jump, id_jump_reg;
	ex_ctrl_t             id_ex_ctrl;
	mem_ctrl_t            id_mem_ctrl;
	wb_ctrl_t             id_wb_ctrl;

	// EX outputs
	logic [`MIPS_LEN-1:0] ex_alu_out, ex_store_data, ex_branch_target;
	logic [`MIPS_NB-1:0]  ex_write_reg;
	logic                 ex_zero;
	mem_ctrl_t            ex_mem_ctrl;
	wb_ctrl_t             ex_wb_ctrl;

	// MEM outputs, also the write-back bus
	logic                 mem_branch_taken, mem_wb_reg_write;
	logic [`MIPS_LEN-1:0] mem_branch_target, mem_wb_data;
	logic [`MIPS_NB-1:0]  mem_wb_reg;

	instruction_fetch u_instruction_fetch (
		.clk(clk), .arst_n(arst_n), .run(run),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.jump(id_jump), .jump_reg(id_jump_reg),
		.jump_target(id_jump_target), .reg_target(id_reg_target),
		.branch_taken(mem_branch_taken), .branch_target(mem_branch_target),
		.pc_plus4(if_pc_plus4), .instruction(if_instruction)
	);

	decode u_decode (
		.clk(clk), .arst_n(arst_n),
		.pc_plus4_in(if_pc_plus4), .instruction(if_instruction),
		.reg_write(mem_wb_reg_write), .write_reg(mem_wb_reg), .write_data(mem_wb_data),
		.pc_plus4(id_pc_plus4), .reg1(id_reg1), .reg2(id_reg2), .sign_ext(id_sign_ext),
		.rs(id_rs), .rt(id_rt), .rd(id_rd), .shamt(id_shamt),
		.ex_ctrl(id_ex_ctrl), .mem_ctrl(id_mem_ctrl), .wb_ctrl(id_wb_ctrl),
		.jump(id_jump), .jump_reg(id_jump_reg),
		.jump_target(id_jump_target), .reg_target(id_reg_target)
	);

	execute u_execute (
		.clk(clk), .arst_n(arst_n),
		.pc_plus4(id_pc_plus4), .reg1(id_reg1), .reg2(id_reg2), .sign_ext(id_sign_ext),
		.rs(id_rs), .rt(id_rt), .rd(id_rd), .shamt(id_shamt),
		.ex_ctrl(id_ex_ctrl), .mem_ctrl_in(id_mem_ctrl), .wb_ctrl_in(id_wb_ctrl),
		.mem_reg_write(ex_wb_ctrl.reg_write), .mem_write_reg(ex_write_reg),
		.mem_fwd(ex_alu_out),
		.wb_reg_write(mem_wb_reg_write), .wb_write_reg(mem_wb_reg), .wb_fwd(mem_wb_data),
		.alu_out(ex_alu_out), .zero(ex_zero), .store_data(ex_store_data),
		.write_reg(ex_write_reg), .branch_target(ex_branch_target),
		.mem_ctrl(ex_mem_ctrl), .wb_ctrl(ex_wb_ctrl)
	);

	memory u_memory (
		.clk(clk), .arst_n(arst_n),
		.alu_out(ex_alu_out), .zero(ex_zero), .store_data(ex_store_data),
		.write_reg_in(ex_write_reg), .branch_target_in(ex_branch_target),
		.mem_ctrl(ex_mem_ctrl), .wb_ctrl_in(ex_wb_ctrl),
		.branch_taken(mem_branch_taken), .branch_target(mem_branch_target),
		.wb_reg_write(mem_wb_reg_write), .wb_reg(mem_wb_reg), .wb_data(mem_wb_data)
	);

	// Retire trace
	assign wb_en   = mem_wb_reg_write;
	assign wb_reg  = mem_wb_reg;
	assign wb_data = mem_wb_data;

endmodule

// ==== source/memory.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module memory (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [`MIPS_LEN-1:0]     alu_out,
	input  logic                     zero,
	input  logic [`MIPS_LEN-1:0]     store_data,
	input  logic [`MIPS_NB-1:0]      write_reg_in,
	input  logic [`MIPS_LEN-1:0]     branch_target_in,
	input  mips_ctrl_pkg::mem_ctrl_t mem_ctrl,
	input  mips_ctrl_pkg::wb_ctrl_t  wb_ctrl_in,
	output logic                     branch_taken,
	output logic [`MIPS_LEN-1:0]     branch_target,
	output logic                     wb_reg_write,
	output logic [`MIPS_NB-1:0]      wb_reg,
	output logic [`MIPS_LEN-1:0]     wb_data
);
	import mips_ctrl_pkg::*;

	logic [`MIPS_LEN-1:0] dmem [`DMEM_DEPTH];
	logic [`DMEM_AW-1:0]  word_idx;
	logic [`MIPS_LEN-1:0] load_data;

	assign word_idx = alu_out[`DMEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (mem_ctrl.mem_write)
			dmem[word_idx] <= store_data;
	end

	assign load_data = mem_ctrl.mem_read ? dmem[word_idx] : '0;

	// beq resolves here
	assign branch_taken  = mem_ctrl.branch & zero;
	assign branch_target = branch_target_in;

	// MEM/WB register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_reg_write <= 1'b0;
			wb_reg       <= '0;
			wb_data      <= '0;
		end else begin
			wb_reg_write <= wb_ctrl_in.reg_write;
			wb_reg       <= write_reg_in;
			wb_data      <= wb_ctrl_in.mem_to_reg ? load_data : alu_out;
		end
	end

endmodule

// ==== source/execute.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module execute (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [`MIPS_LEN-1:0]     pc_plus4,
	input  logic [`MIPS_LEN-1:0]     reg1,
	input  logic [`MIPS_LEN-1:0]     reg2,
	input  logic [`MIPS_LEN-1:0]     sign_ext,
	input  logic [`MIPS_NB-1:0]      rs,
	input  logic [`MIPS_NB-1:0]      rt,
	input  logic [`MIPS_NB-1:0]      rd,
	input  logic [`MIPS_NB-1:0]      shamt,
	input  mips_ctrl_pkg::ex_ctrl_t  ex_ctrl,
	input  mips_ctrl_pkg::mem_ctrl_t mem_ctrl_in,
	input  mips_ctrl_pkg::wb_ctrl_t  wb_ctrl_in,
	input  logic                     mem_reg_write,
	input  logic [`MIPS_NB-1:0]      mem_write_reg,
	input  logic [`MIPS_LEN-1:0]     mem_fwd,
	input  logic                     wb_reg_write,
	input  logic [`MIPS_NB-1:0]      wb_write_reg,
	input  logic [`MIPS_LEN-1:0]     wb_fwd,
	output logic [`MIPS_LEN-1:0]     alu_out,
	output logic                     zero,
	output logic [`MIPS_LEN-1:0]     store_data,
	output logic [`MIPS_NB-1:0]      write_reg,
	output logic [`MIPS_LEN-1:0]     branch_target,
	output mips_ctrl_pkg::mem_ctrl_t mem_ctrl,
	output mips_ctrl_pkg::wb_ctrl_t  wb_ctrl
);
	import mips_ctrl_pkg::*;

	logic [`MIPS_LEN-1:0] op_a;
	logic [`MIPS_LEN-1:0] op_b_reg;
	logic [`MIPS_LEN-1:0] op_b;
	logic [`MIPS_LEN-1:0] alu_res;

	// Youngest producer first and r0 never forwarded
	always_comb begin
		if (rs != '0 && mem_reg_write && mem_write_reg == rs)
			op_a = mem_fwd;
		else if (rs != '0 && wb_reg_write && wb_write_reg == rs)
			op_a = wb_fwd;
		else
			op_a = reg1;
	end

	always_comb begin
		if (rt != '0 && mem_reg_write && mem_write_reg == rt)
			op_b_reg = mem_fwd;
		else if (rt != '0 && wb_reg_write && wb_write_reg == rt)
			op_b_reg = wb_fwd;
		else
			op_b_reg = reg2;
	end

	assign op_b = ex_ctrl.alu_src_imm ? sign_ext : op_b_reg;

	//////////////////////////////
	// ALU

	always_comb begin
		case (ex_ctrl.alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_OR:  alu_res = op_a | op_b;
			ALU_SLT: alu_res = {{(`MIPS_LEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLL: alu_res = op_b << shamt;
			default: alu_res = '0;
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			alu_out       <= '0;
			zero          <= 1'b0;
			store_data    <= '0;
			write_reg     <= '0;
			branch_target <= '0;
			mem_ctrl      <= '0;
			wb_ctrl       <= '0;
		end else begin
			alu_out       <= alu_res;
			zero          <= (alu_res == '0);
			store_data    <= op_b_reg;
			write_reg     <= ex_ctrl.reg_dst_rd ? rd : rt;
			branch_target <= pc_plus4 + (sign_ext << 2);
			mem_ctrl      <= mem_ctrl_in;
			wb_ctrl       <= wb_ctrl_in;
		end
	end

endmodule

// ==== source/decode.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module decode (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [`MIPS_LEN-1:0]    pc_plus4_in,
	input  mips_isa_pkg::instr_t    instruction,
	input  logic                    reg_write,
	input  logic [`MIPS_NB-1:0]     write_reg,
	input  logic [`MIPS_LEN-1:0]    write_data,
	output logic [`MIPS_LEN-1:0]    pc_plus4,
	output logic [`MIPS_LEN-1:0]    reg1,
	output logic [`MIPS_LEN-1:0]    reg2,
	output logic [`MIPS_LEN-1:0]    sign_ext,
	output logic [`MIPS_NB-1:0]     rs,
	output logic [`MIPS_NB-1:0]     rt,
	output logic [`MIPS_NB-1:0]     rd,
	output logic [`MIPS_NB-1:0]     shamt,
	output mips_ctrl_pkg::ex_ctrl_t  ex_ctrl,
	output mips_ctrl_pkg::mem_ctrl_t mem_ctrl,
	output mips_ctrl_pkg::wb_ctrl_t  wb_ctrl,
	output logic                    jump,
	output logic                    jump_reg,
	output logic [`MIPS_LEN-1:0]    jump_target,
	output logic [`MIPS_LEN-1:0]    reg_target
);
	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	logic [`MIPS_LEN-1:0] regs [2**`MIPS_NB];
	logic [`MIPS_LEN-1:0] rd1;
	logic [`MIPS_LEN-1:0] rd2;
	logic [`MIPS_LEN-1:0] imm_ext;
	ex_ctrl_t             ex_c;
	mem_ctrl_t            mem_c;
	wb_ctrl_t             wb_c;

	//////////////////////////////
	// Register file

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**`MIPS_NB; i++)
				regs[i] <= '0;
		end else if (reg_write && write_reg != '0) begin
			regs[write_reg] <= write_data;
		end
	end

	// Same-cycle write shows through to the read
	assign rd1 = (instruction.i.rs == '0) ? '0 :
		(reg_write && write_reg == instruction.i.rs) ? write_data : regs[instruction.i.rs];
	assign rd2 = (instruction.i.rt == '0) ? '0 :
		(reg_write && write_reg == instruction.i.rt) ? write_data : regs[instruction.i.rt];

	assign imm_ext     = {{(`MIPS_LEN-16){instruction.i.imm16[15]}}, instruction.i.imm16};
	assign jump_target = {pc_plus4_in[`MIPS_LEN-1 -: 4], instruction.j.target26, 2'b00};
	assign reg_target  = rd1;

	//////////////////////////////
	// Control decoder

	always_comb begin
		ex_c     = '0;
		mem_c    = '0;
		wb_c     = '0;
		jump     = 1'b0;
		jump_reg = 1'b0;
		case (instruction.r.opcode)
			OP_RTYPE: begin
				ex_c.reg_dst_rd = 1'b1;
				wb_c.reg_write  = 1'b1;
				case (instruction.r.funct)
					FN_ADDU: ex_c.alu_op = ALU_ADD;
					FN_SUBU: ex_c.alu_op = ALU_SUB;
					FN_AND:  ex_c.alu_op = ALU_AND;
					FN_OR:   ex_c.alu_op = ALU_OR;
					FN_SLT:  ex_c.alu_op = ALU_SLT;
					FN_SLL:  ex_c.alu_op = ALU_SLL;
					FN_JR: begin
						jump_reg       = 1'b1;
						wb_c.reg_write = 1'b0;
					end
					default: wb_c.reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				ex_c.alu_src_imm = 1'b1;
				wb_c.reg_write   = 1'b1;
			end
			OP_LW: begin
				ex_c.alu_src_imm = 1'b1;
				mem_c.mem_read   = 1'b1;
				wb_c.reg_write   = 1'b1;
				wb_c.mem_to_reg  = 1'b1;
			end
			OP_SW: begin
				ex_c.alu_src_imm = 1'b1;
				mem_c.mem_write  = 1'b1;
			end
			OP_BEQ: begin
				ex_c.alu_op  = ALU_SUB;
				mem_c.branch = 1'b1;
			end
			OP_J:    jump = 1'b1;
			default: ;
		endcase
		// The all-zero word is a bubble and retires nothing
		if (instruction == INSTR_NOP)
			wb_c = '0;
	end

	// ID/EX register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_plus4 <= '0;
			reg1     <= '0;
			reg2     <= '0;
			sign_ext <= '0;
			rs       <= '0;
			rt       <= '0;
			rd       <= '0;
			shamt    <= '0;
			ex_ctrl  <= '0;
			mem_ctrl <= '0;
			wb_ctrl  <= '0;
		end else begin
			pc_plus4 <= pc_plus4_in;
			reg1     <= rd1;
			reg2     <= rd2;
			sign_ext <= imm_ext;
			rs       <= instruction.i.rs;
			rt       <= instruction.i.rt;
			rd       <= instruction.r.rd;
			shamt    <= instruction.r.shamt;
			ex_ctrl  <= ex_c;
			mem_ctrl <= mem_c;
			wb_ctrl  <= wb_c;
		end
	end

endmodule

// ==== source/instruction_fetch.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module instruction_fetch (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 run,
	input  logic                 imem_we,
	input  logic [`IMEM_AW-1:0]  imem_addr,
	input  mips_isa_pkg::instr_t imem_wdata,
	input  logic                 jump,
	input  logic                 jump_reg,
	input  logic [`MIPS_LEN-1:0] jump_target,
	input  logic [`MIPS_LEN-1:0] reg_target,
	input  logic                 branch_taken,
	input  logic [`MIPS_LEN-1:0] branch_target,
	output logic [`MIPS_LEN-1:0] pc_plus4,
	output mips_isa_pkg::instr_t instruction
);
	import mips_isa_pkg::*;

	instr_t               imem [`IMEM_DEPTH];
	logic [`MIPS_LEN-1:0] pc;
	logic [`MIPS_LEN-1:0] pc_inc;
	logic [`MIPS_LEN-1:0] pc_next;

	// Program load, only while halted
	always_ff @(posedge clk) begin
		if (imem_we && !run)
			imem[imem_addr] <= imem_wdata;
	end

	assign pc_inc = pc + `MIPS_LEN'd4;

	// Branch from MEM wins over jumps from ID
	always_comb begin
		if (branch_taken)
			pc_next = branch_target;
		else if (jump_reg)
			pc_next = reg_target;
		else if (jump)
			pc_next = jump_target;
		else
			pc_next = pc_inc;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc          <= '0;
			pc_plus4    <= '0;
			instruction <= INSTR_NOP;
		end else begin
			pc_plus4 <= pc_inc;
			if (run) begin
				pc          <= pc_next;
				instruction <= imem[pc[`IMEM_AW+1:2]];
			end else begin
				instruction <= INSTR_NOP;
			end
		end
	end

endmodule

// ==== source/mips_ctrl_pkg.sv ====
package mips_ctrl_pkg;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4,
		ALU_SLL = 3'd5
	} alu_op_e;

	// Execute stage controls
	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;
		logic    reg_dst_rd;
	} ex_ctrl_t;

	// Memory stage controls
	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic branch;
	} mem_ctrl_t;

	// Write-back controls
	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

endpackage

// ==== source/mips_isa_pkg.sv ====
`include "mips_params.svh"

package mips_isa_pkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDIU = 6'h09,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// R-type function codes
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef struct packed {
		opcode_e            opcode;
		logic [`MIPS_NB-1:0] rs;
		logic [`MIPS_NB-1:0] rt;
		logic [`MIPS_NB-1:0] rd;
		logic [`MIPS_NB-1:0] shamt;
		funct_e             funct;
	} r_type_t;

	typedef struct packed {
		opcode_e            opcode;
		logic [`MIPS_NB-1:0] rs;
		logic [`MIPS_NB-1:0] rt;
		logic [15:0]        imm16;
	} i_type_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] target26;
	} j_type_t;

	// Same word seen through all three formats
	typedef union packed {
		r_type_t r;
		i_type_t i;
		j_type_t j;
	} instr_t;

	// sll r0, r0, 0
	localparam instr_t INSTR_NOP = '0;

endpackage

// ==== source/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data and address width
`define MIPS_LEN 32

// Register index width
`define MIPS_NB 5

// Memory depths in words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

// Word index widths for the two memories
`define IMEM_AW $clog2(`IMEM_DEPTH)
`define DMEM_AW $clog2(`DMEM_DEPTH)

`endif
